// File: list.f
tlul_shim_pkg.sv
tlul_req_build.sv
tlul_intg_gen.sv
sub2tlul.sv
tlul_sram.sv
tlul_shim_top.sv
tb_tlul_shim.sv

// File: Makefile
# Verilator flow for the TL-UL shim testbench

VERILATOR ?= verilator
TOP       ?= tb_tlul_shim
FLIST     ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_MSG  ?= Everything OK

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

# Pass only when the pass line shows up in the simulation output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb_tlul_shim.sv
module tb_tlul_shim;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int C_LAT     = 4;              // Longer than default, stretches the hold
    localparam int MEM_WORDS = 64;
    localparam int TIMEOUT   = 100;            // Cycles per wait loop

    logic                 clk;
    logic                 rst_n;
    logic                 dv_i;
    tlul_shim_pkg::addr_t addr_i;
    logic                 write_i;
    tlul_shim_pkg::id_t   id_i;
    tlul_shim_pkg::data_t wdata_i;
    tlul_shim_pkg::strb_t wstrb_i;
    tlul_shim_pkg::size_t size_i;
    tlul_shim_pkg::data_t rdata_o;
    logic                 hld_o;
    logic                 rd_err_o;
    logic                 wr_err_o;

    tlul_shim_pkg::data_t ref_mem [MEM_WORDS];  // Mirror of legal writes
    logic [31:0]          seed;
    int                   a_beats;              // A-channel transfers seen
    int                   hold_cycles;          // hld_o high cycles of last access
    tlul_shim_pkg::data_t rd_data;
    logic                 rd_err;
    logic                 wr_err;

    tlul_shim_top #(
        .C_LAT     (C_LAT),
        .MEM_WORDS (MEM_WORDS)
    ) u_tlul_shim_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .dv_i     (dv_i),
        .addr_i   (addr_i),
        .write_i  (write_i),
        .id_i     (id_i),
        .wdata_i  (wdata_i),
        .wstrb_i  (wstrb_i),
        .size_i   (size_i),
        .rdata_o  (rdata_o),
        .hld_o    (hld_o),
        .rd_err_o (rd_err_o),
        .wr_err_o (wr_err_o)
    );

    always #20 clk = ~clk;                     // 40 ns period

    // Count A beats on the internal TL-UL link
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_beats <= 0;
        end else if (u_tlul_shim_top.tl_h2d.a_valid && u_tlul_shim_top.tl_d2h.a_ready) begin
            a_beats <= a_beats + 1;
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] lcg();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic tlul_shim_pkg::addr_t rand_addr();
        logic [31:0] word;
        word = lcg() % 32'(MEM_WORDS);         // Word index in range
        return word << 2;
    endfunction

    function automatic tlul_shim_pkg::data_t merge_bytes(input tlul_shim_pkg::data_t old_w,
                                                         input tlul_shim_pkg::data_t new_w,
                                                         input tlul_shim_pkg::strb_t strb);
        tlul_shim_pkg::data_t res;
        res = old_w;
        for (int b = 0; b < tlul_shim_pkg::BC; b++) begin
            if (strb[b]) res[b*8 +: 8] = new_w[b*8 +: 8];    // Only selected lanes
        end
        return res;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // One full request; dv_i is left high for a back-to-back follow-up
    task automatic do_access(input tlul_shim_pkg::addr_t addr, input logic write,
                             input tlul_shim_pkg::id_t id, input tlul_shim_pkg::data_t wdata,
                             input tlul_shim_pkg::strb_t wstrb);
        int cnt;
        @(posedge clk);
        dv_i    <= 1'b1;
        addr_i  <= addr;
        write_i <= write;
        id_i    <= id;
        wdata_i <= wdata;
        wstrb_i <= wstrb;
        size_i  <= 2'd2;                       // Full word
        hold_cycles = 0;
        cnt         = 0;
        @(negedge clk);
        while (hld_o && cnt < TIMEOUT) begin
            hold_cycles++;
            cnt++;
            @(negedge clk);
        end
        if (hld_o) begin
            $display("Timeout: hld_o never fell for the request at address %h", addr);
            $display("Something failed");
            $fatal(1);
        end else begin
            rd_data = rdata_o;                 // Response cycle, outputs valid
            rd_err  = rd_err_o;
            wr_err  = wr_err_o;
            if (write && (addr >> 2) < 32'(MEM_WORDS)) begin
                ref_mem[int'(addr >> 2)] = merge_bytes(ref_mem[int'(addr >> 2)], wdata, wstrb);
            end
        end
    endtask

    task automatic release_bus();
        @(posedge clk);
        dv_i <= 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) @(negedge clk);
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic test_reset();
        @(negedge clk);
        check("reset hld_o", 32'd0, 32'(hld_o));
        check("reset rd_err_o", 32'd0, 32'(rd_err_o));
        check("reset wr_err_o", 32'd0, 32'(wr_err_o));
    endtask

    task automatic test_full_write_read();
        tlul_shim_pkg::addr_t addrs [6];
        for (int i = 0; i < 6; i++) begin
            addrs[i] = rand_addr();
            do_access(addrs[i], 1'b1, 2'(i), lcg(), 4'hf);
            check("full_write_read wr_err", 32'd0, 32'(wr_err));
            release_bus();
        end
        for (int i = 0; i < 6; i++) begin
            do_access(addrs[i], 1'b0, 2'(i), '0, 4'h0);
            check("full_write_read data", ref_mem[int'(addrs[i] >> 2)], rd_data);
            check("full_write_read rd_err", 32'd0, 32'(rd_err));
            release_bus();
        end
    endtask

    task automatic test_partial_write();
        tlul_shim_pkg::addr_t addr;
        tlul_shim_pkg::data_t old_w;
        tlul_shim_pkg::data_t new_w;
        addr  = 32'd40 << 2;
        old_w = lcg();
        new_w = lcg();
        do_access(addr, 1'b1, 2'd1, old_w, 4'hf);
        release_bus();
        do_access(addr, 1'b1, 2'd2, new_w, 4'b0101);     // Lanes 0 and 2
        check("partial_write wr_err", 32'd0, 32'(wr_err));
        release_bus();
        do_access(addr, 1'b0, 2'd3, '0, 4'h0);
        check("partial_write data", merge_bytes(old_w, new_w, 4'b0101), rd_data);
        release_bus();
    endtask

    task automatic test_out_of_range();
        tlul_shim_pkg::addr_t in_addr;
        tlul_shim_pkg::addr_t oor_addr;
        in_addr  = 32'd3 << 2;
        oor_addr = 32'(MEM_WORDS + 3) << 2;    // Aliases word 3 in the low index bits
        do_access(in_addr, 1'b1, 2'd0, lcg(), 4'hf);
        release_bus();
        do_access(oor_addr, 1'b1, 2'd1, lcg(), 4'hf);
        check("out_of_range wr_err", 32'd1, 32'(wr_err));
        release_bus();
        do_access(in_addr, 1'b0, 2'd2, '0, 4'h0);
        check("out_of_range unchanged", ref_mem[3], rd_data);
        check("out_of_range rd_err in", 32'd0, 32'(rd_err));
        release_bus();
        do_access(oor_addr, 1'b0, 2'd3, '0, 4'h0);
        check("out_of_range rd_err", 32'd1, 32'(rd_err));
        check("out_of_range rdata", 32'd0, rd_data);
        release_bus();
    endtask

    task automatic test_hold_until_response();
        int beats0;
        tlul_shim_pkg::addr_t addr;
        addr = 32'd10 << 2;
        @(negedge clk);
        beats0 = a_beats;
        do_access(addr, 1'b1, 2'd2, lcg(), 4'hf);
        check("hold_until_response long hold", 32'd1, 32'(hold_cycles >= C_LAT));
        release_bus();
        idle_cycles(2 * C_LAT);                // Let any stray A beat show up
        check("hold_until_response one A beat", 32'd1, 32'(a_beats - beats0));
        do_access(addr, 1'b0, 2'd1, '0, 4'h0);
        check("hold_until_response data", ref_mem[10], rd_data);
        release_bus();
    endtask

    task automatic test_back_to_back();
        for (int i = 0; i < 4; i++) begin
            do_access(32'(20 + i) << 2, 1'b1, 2'(i), lcg(), 4'hf);    // No gap between
            check("back_to_back wr_err", 32'd0, 32'(wr_err));
        end
        for (int i = 3; i >= 0; i--) begin
            do_access(32'(20 + i) << 2, 1'b0, 2'(i), '0, 4'h0);
            check("back_to_back data", ref_mem[20 + i], rd_data);
            check("back_to_back rd_err", 32'd0, 32'(rd_err));
        end
        release_bus();
    endtask

    initial begin
        seed    = 32'h51b9;
        clk     = 1'b0;
        rst_n   = 1'b0;
        dv_i    = 1'b0;
        addr_i  = '0;
        write_i = 1'b0;
        id_i    = '0;
        wdata_i = '0;
        wstrb_i = '0;
        size_i  = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_full_write_read();
        test_partial_write();
        test_out_of_range();
        test_hold_until_response();
        test_back_to_back();
        $display("Everything OK");
        $finish;
    end

endmodule

// File: tlul_shim_top.sv
module tlul_shim_top #(
    parameter int C_LAT     = 2,
    parameter int MEM_WORDS = 64
) (
    input  logic                 clk,
    input  logic                 rst_n,
    // Component side
    input  logic                 dv_i,
    input  tlul_shim_pkg::addr_t addr_i,
    input  logic                 write_i,
    input  tlul_shim_pkg::id_t   id_i,
    input  tlul_shim_pkg::data_t wdata_i,
    input  tlul_shim_pkg::strb_t wstrb_i,
    input  tlul_shim_pkg::size_t size_i,
    output tlul_shim_pkg::data_t rdata_o,
    output logic                 hld_o,
    output logic                 rd_err_o,
    output logic                 wr_err_o
);

    tlul_shim_pkg::req_t    req;
    tlul_shim_pkg::req_op_t req_op;
    logic                   req_vld;
    tlul_shim_pkg::tl_h2d_t pay;
    logic                   pay_vld;
    tlul_shim_pkg::tl_h2d_t tl_h2d;
    tlul_shim_pkg::tl_d2h_t tl_d2h;
    logic                   done;

    assign req = '{addr: addr_i, write: write_i, id: id_i,
                   wdata: wdata_i, wstrb: wstrb_i, size: size_i};

    // ------------------------------
    // Request -> integrity -> bridge
    // ------------------------------
    tlul_req_build u_tlul_req_build (
        .clk       (clk),
        .rst_n     (rst_n),
        .dv_i      (dv_i),
        .req_i     (req),
        .done_i    (done),
        .req_o     (req_op),
        .req_vld_o (req_vld)
    );

    tlul_intg_gen u_tlul_intg_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_i     (req_op),
        .req_vld_i (req_vld),
        .pay_o     (pay),
        .pay_vld_o (pay_vld)
    );

    sub2tlul u_sub2tlul (
        .clk       (clk),
        .rst_n     (rst_n),
        .pay_i     (pay),
        .pay_vld_i (pay_vld),
        .dv_i      (dv_i),
        .tl_o      (tl_h2d),
        .tl_i      (tl_d2h),
        .rdata_o   (rdata_o),
        .hld_o     (hld_o),
        .rd_err_o  (rd_err_o),
        .wr_err_o  (wr_err_o),
        .done_o    (done)
    );

    // TL-UL target
    tlul_sram #(
        .C_LAT     (C_LAT),
        .MEM_WORDS (MEM_WORDS)
    ) u_tlul_sram (
        .clk       (clk),
        .rst_n     (rst_n),
        .tl_i      (tl_h2d),
        .tl_o      (tl_d2h)
    );

endmodule

// File: tlul_sram.sv
module tlul_sram #(
    parameter int C_LAT     = 2,               // A accept to D valid, at least 1
    parameter int MEM_WORDS = 64
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  tlul_shim_pkg::tl_h2d_t tl_i,
    output tlul_shim_pkg::tl_d2h_t tl_o
);

    localparam int IDXW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CW   = (C_LAT > 1) ? $clog2(C_LAT) : 1;

    tlul_shim_pkg::data_t      mem [MEM_WORDS];
    logic                      busy;           // Transaction outstanding
    logic [CW-1:0]             cnt;            // Cycles left to response
    logic                      a_acc;
    logic                      d_beat;
    logic                      is_put;
    logic                      in_range;
    logic                      aligned;
    logic                      intg_ok;
    logic                      legal;
    logic [IDXW-1:0]           idx;
    tlul_shim_pkg::cmd_intg_t  cmd_chk;
    tlul_shim_pkg::data_intg_t data_chk;
    tlul_shim_pkg::tl_d_op_e   rsp_op;
    tlul_shim_pkg::id_t        rsp_src;
    tlul_shim_pkg::data_t      rsp_data;
    logic                      rsp_err;

    // ------------------------------
    // Request checks
    // ------------------------------
    assign a_acc    = tl_i.a_valid && !busy;
    assign is_put   = tl_i.a_opcode != tlul_shim_pkg::Get;
    assign idx      = tl_i.a_address[IDXW+1:2];
    assign aligned  = tl_i.a_address[1:0] == 2'b00;
    assign in_range = tl_i.a_address[tlul_shim_pkg::AW-1:2] <
                      (tlul_shim_pkg::AW - 2)'(MEM_WORDS);

    // Same fold as the generator side
    assign cmd_chk  = tlul_shim_pkg::intg_fold(
                          tlul_shim_pkg::fold_t'({tl_i.a_address, tl_i.a_opcode, tl_i.a_mask}));
    assign data_chk = tlul_shim_pkg::intg_fold(tlul_shim_pkg::fold_t'(tl_i.a_data));
    assign intg_ok  = (cmd_chk == tl_i.a_user.cmd_intg) &&
                      (data_chk == tl_i.a_user.data_intg) &&
                      (tl_i.a_user.instr_type == tlul_shim_pkg::INSTR_DATA);
    assign legal    = aligned && in_range && intg_ok;

    // ------------------------------
    // Latency counter
    // ------------------------------
    assign d_beat = tl_o.d_valid && tl_i.d_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (a_acc) begin
            busy <= 1'b1;
            cnt  <= CW'(C_LAT - 1);
        end else if (busy && cnt != '0) begin
            cnt  <= cnt - 1'b1;
        end else if (d_beat) begin
            busy <= 1'b0;                      // Ready for next A beat
        end
    end

    // Byte-masked write, only for legal puts
    always_ff @(posedge clk) begin
        if (a_acc && legal && is_put) begin
            for (int b = 0; b < tlul_shim_pkg::BC; b++) begin
                if (tl_i.a_mask[b]) mem[idx][b*8 +: 8] <= tl_i.a_data[b*8 +: 8];
            end
        end
    end

    // Response captured at accept, read before write
    always_ff @(posedge clk) begin
        if (a_acc) begin
            rsp_op   <= is_put ? tlul_shim_pkg::AccessAck : tlul_shim_pkg::AccessAckData;
            rsp_src  <= tl_i.a_source;
            rsp_data <= (legal && !is_put) ? mem[idx] : '0;
            rsp_err  <= !legal;
        end
    end

    assign tl_o.d_valid  = busy && cnt == '0;
    assign tl_o.d_opcode = rsp_op;
    assign tl_o.d_source = rsp_src;
    assign tl_o.d_data   = rsp_data;
    assign tl_o.d_error  = rsp_err;
    assign tl_o.a_ready  = !busy;              // One outstanding transaction

endmodule

// File: sub2tlul.sv
module sub2tlul (
    input  logic                   clk,
    input  logic                   rst_n,
    input  tlul_shim_pkg::tl_h2d_t pay_i,
    input  logic                   pay_vld_i,
    input  logic                   dv_i,
    output tlul_shim_pkg::tl_h2d_t tl_o,
    input  tlul_shim_pkg::tl_d2h_t tl_i,
    output tlul_shim_pkg::data_t   rdata_o,
    output logic                   hld_o,
    output logic                   rd_err_o,
    output logic                   wr_err_o,
    output logic                   done_o      // Pulse on matching D beat
);

    typedef enum logic [1:0] {
        txn_idle     = 2'b00,
        txn_a_pend   = 2'b01,                  // A valid, not yet accepted
        txn_wait_get = 2'b10,
        txn_wait_put = 2'b11
    } txn_state_e;

    txn_state_e state;
    txn_state_e state_nxt;
    logic       a_valid;
    logic       a_acc;
    logic       is_get;
    logic       d_match;
    logic       d_beat;

    // ------------------------------
    // A channel
    // ------------------------------
    assign a_valid = (state == txn_idle && pay_vld_i) || state == txn_a_pend;
    assign a_acc   = a_valid && tl_i.a_ready;
    assign is_get  = pay_i.a_opcode == tlul_shim_pkg::Get;

    always_comb begin
        tl_o         = pay_i;
        tl_o.a_valid = a_valid;
        tl_o.d_ready = 1'b1;                   // Response always taken
    end

    always_comb begin
        state_nxt = state;
        case (state)
            txn_idle, txn_a_pend: begin
                if (a_acc) begin
                    state_nxt = is_get ? txn_wait_get : txn_wait_put;
                end else if (a_valid) begin
                    state_nxt = txn_a_pend;    // Target back-pressure
                end
            end
            txn_wait_get, txn_wait_put: begin
                if (d_beat) state_nxt = txn_idle;
            end
            default: state_nxt = txn_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) state <= txn_idle;
        else        state <= state_nxt;
    end

    // ------------------------------
    // D channel to component
    // ------------------------------
    assign d_match = tl_i.d_valid && tl_o.d_ready && (tl_i.d_source == pay_i.a_source);
    assign d_beat  = d_match &&
                     ((state == txn_wait_get && tl_i.d_opcode == tlul_shim_pkg::AccessAckData) ||
                      (state == txn_wait_put && tl_i.d_opcode == tlul_shim_pkg::AccessAck));

    assign hld_o    = dv_i && !d_beat;         // Release only on own response
    assign done_o   = d_beat;
    assign rdata_o  = (d_beat && state == txn_wait_get) ? tl_i.d_data : '0;
    assign rd_err_o = d_beat && state == txn_wait_get && tl_i.d_error;
    assign wr_err_o = d_beat && state == txn_wait_put && tl_i.d_error;

endmodule

// File: tlul_intg_gen.sv
module tlul_intg_gen (
    input  logic                   clk,
    input  logic                   rst_n,
    input  tlul_shim_pkg::req_op_t req_i,
    input  logic                   req_vld_i,
    output tlul_shim_pkg::tl_h2d_t pay_o,      // A payload, valid/ready left low
    output logic                   pay_vld_o   // One cycle per new request
);

    logic                      req_vld_q;
    logic                      new_req;
    tlul_shim_pkg::cmd_intg_t  cmd_intg;
    tlul_shim_pkg::data_intg_t data_intg;
    tlul_shim_pkg::tl_a_user_t a_user;

    assign new_req = req_vld_i && !req_vld_q;  // Rising edge of request valid

    // Command code covers address, opcode and mask
    assign cmd_intg  = tlul_shim_pkg::intg_fold(
                           tlul_shim_pkg::fold_t'({req_i.req.addr, req_i.opcode, req_i.mask}));
    assign data_intg = tlul_shim_pkg::intg_fold(tlul_shim_pkg::fold_t'(req_i.req.wdata));

    assign a_user = '{rsvd:       '0,
                      instr_type: tlul_shim_pkg::INSTR_DATA,
                      cmd_intg:   cmd_intg,
                      data_intg:  data_intg};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_vld_q <= 1'b0;
            pay_vld_o <= 1'b0;
        end else begin
            req_vld_q <= req_vld_i;
            pay_vld_o <= new_req;
        end
    end

    // Payload register; stays put until the next request
    always_ff @(posedge clk) begin
        if (new_req) begin
            pay_o <= '{a_valid:   1'b0,
                       a_opcode:  req_i.opcode,
                       a_param:   3'h0,           // Unused in TL-UL
                       a_size:    req_i.req.size,
                       a_source:  req_i.req.id,
                       a_address: req_i.req.addr,
                       a_mask:    req_i.mask,
                       a_data:    req_i.req.wdata,
                       a_user:    a_user,
                       d_ready:   1'b0};
        end
    end

endmodule

// File: tlul_req_build.sv
module tlul_req_build (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   dv_i,       // Component request level
    input  tlul_shim_pkg::req_t    req_i,
    input  logic                   done_i,     // Pulse from bridge on D beat
    output tlul_shim_pkg::req_op_t req_o,
    output logic                   req_vld_o
);

    logic                    busy;             // Request captured, not yet answered
    logic                    load;
    tlul_shim_pkg::tl_a_op_e opcode;
    tlul_shim_pkg::strb_t    rd_mask;
    tlul_shim_pkg::strb_t    mask;

    assign load = dv_i && !busy;

    // Read mask from size and low address bits
    always_comb begin
        case (req_i.size)
            2'd0:    rd_mask = 4'b0001 << req_i.addr[1:0];          // Byte
            2'd1:    rd_mask = 4'b0011 << {req_i.addr[1], 1'b0};    // Half word
            default: rd_mask = '1;                                  // Full word
        endcase
    end

    // Full strobes map to PutFullData
    assign opcode = !req_i.write ? tlul_shim_pkg::Get :
                    (req_i.wstrb == '1) ? tlul_shim_pkg::PutFullData :
                                          tlul_shim_pkg::PutPartialData;
    assign mask   = req_i.write ? req_i.wstrb : rd_mask;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (load) begin
            busy <= 1'b1;
        end else if (done_i) begin
            busy <= 1'b0;                      // Free for the next request
        end
    end

    // Request snapshot, held for the whole transaction
    always_ff @(posedge clk) begin
        if (load) begin
            req_o <= '{req: req_i, opcode: opcode, mask: mask};
        end
    end

    assign req_vld_o = busy;

endmodule

// File: tlul_shim_pkg.sv
package tlul_shim_pkg;

    // ------------------------------
    // Widths
    // ------------------------------
    parameter int AW      = 32;          // Address
    parameter int DW      = 32;          // Data
    parameter int BC      = DW / 8;      // Byte lanes
    parameter int IW      = 2;           // Source ID
    parameter int SZW     = 2;           // TL size field
    parameter int CMD_IW  = 7;           // Command integrity
    parameter int DATA_IW = 7;           // Data integrity
    parameter int FOLD_W  = 64;          // Fold input, wide enough for addr+opcode+mask

    typedef logic [AW-1:0]      addr_t;
    typedef logic [DW-1:0]      data_t;
    typedef logic [BC-1:0]      strb_t;
    typedef logic [IW-1:0]      id_t;
    typedef logic [SZW-1:0]     size_t;
    typedef logic [CMD_IW-1:0]  cmd_intg_t;
    typedef logic [DATA_IW-1:0] data_intg_t;
    typedef logic [FOLD_W-1:0]  fold_t;

    // TL-UL opcodes, standard encodings
    typedef enum logic [2:0] {
        PutFullData    = 3'h0,
        PutPartialData = 3'h1,
        Get            = 3'h4
    } tl_a_op_e;

    typedef enum logic [2:0] {
        AccessAck     = 3'h0,
        AccessAckData = 3'h1
    } tl_d_op_e;

    // Every access is a data access, never an instruction fetch
    localparam logic [3:0] INSTR_DATA = 4'h9;

    // ------------------------------
    // Channel and stage structs
    // ------------------------------
    typedef struct packed {
        logic [4:0] rsvd;                // Spare, tied low
        logic [3:0] instr_type;
        cmd_intg_t  cmd_intg;
        data_intg_t data_intg;
    } tl_a_user_t;

    typedef struct packed {
        logic       a_valid;
        tl_a_op_e   a_opcode;
        logic [2:0] a_param;
        size_t      a_size;
        id_t        a_source;
        addr_t      a_address;
        strb_t      a_mask;
        data_t      a_data;
        tl_a_user_t a_user;
        logic       d_ready;
    } tl_h2d_t;

    typedef struct packed {
        logic     d_valid;
        tl_d_op_e d_opcode;
        id_t      d_source;
        data_t    d_data;
        logic     d_error;
        logic     a_ready;
    } tl_d2h_t;

    typedef struct packed {
        addr_t addr;
        logic  write;
        id_t   id;
        data_t wdata;
        strb_t wstrb;
        size_t size;
    } req_t;

    typedef struct packed {
        req_t     req;
        tl_a_op_e opcode;
        strb_t    mask;
    } req_op_t;

    // XOR fold into 7 bits; shared by generator and checker
    function automatic logic [CMD_IW-1:0] intg_fold(input fold_t vec);
        logic [CMD_IW-1:0] acc;
        acc = 7'h55;                      // Nonzero seed, all-zero input gives nonzero code
        for (int i = 0; i < FOLD_W; i++) begin
            acc[i % CMD_IW] = acc[i % CMD_IW] ^ vec[i];
        end
        return acc;
    endfunction

endpackage
